/* draw_line.sv */
////////////////////////////////////////////////////////////
// bresenham line drawer
// one pixel per cycle while oe is high
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module draw_line (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,    // begin a line, taken in idle only
    input  logic                  oe,       // low holds position
    input  gfx_coord_pkg::coord_t x0,       // first endpoint
    input  gfx_coord_pkg::coord_t y0,
    input  gfx_coord_pkg::coord_t x1,       // last endpoint
    input  gfx_coord_pkg::coord_t y1,
    output gfx_coord_pkg::coord_t x,        // current pixel
    output gfx_coord_pkg::coord_t y,
    output logic                  drawing,  // x/y valid when oe high
    output logic                  done      // cycle after last pixel
);
    import gfx_coord_pkg::*;

    typedef enum logic [1:0] {st_idle, st_init, st_draw} state_t;

    state_t                    state;
    coord_t                    xa, ya;      // latched start point
    coord_t                    xb, yb;      // latched end point
    coord_t                    sx, sy;      // step of +1 or -1
    logic signed [coord_w:0]   diff_x, diff_y;
    logic signed [coord_w:0]   abs_dx, neg_dy;
    logic signed [coord_w:0]   dx, dy;      // dx >= 0 and dy <= 0
    logic signed [coord_w+1:0] err, err_nx; // bresenham error term
    logic signed [coord_w+2:0] e2;          // twice the error
    logic                      step_x, step_y;
    logic                      at_end;

    assign diff_x = xb - xa;                // 17 bit so no overflow
    assign diff_y = yb - ya;
    assign abs_dx = (diff_x < 0) ? -diff_x : diff_x;
    assign neg_dy = (diff_y < 0) ? diff_y : -diff_y;

    assign e2     = {err, 1'b0};
    assign step_x = (e2 >= dy);             // move along x
    assign step_y = (e2 <= dx);             // move along y
    assign at_end = (x == xb) && (y == yb);

    always_comb begin
        err_nx = err;
        if (step_x)
            err_nx = err_nx + dy;
        if (step_y)
            err_nx = err_nx + dx;
    end

    assign drawing = (state == st_draw);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;                   // single cycle pulse
            case (state)
                st_idle: if (start) state <= st_init;
                st_init: state <= st_draw;
                st_draw: begin
                    if (oe && at_end) begin // last pixel goes out now
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            xa <= x0;
            ya <= y0;
            xb <= x1;
            yb <= y1;
        end
        if (state == st_init) begin
            x   <= xa;                      // first pixel is (x0,y0)
            y   <= ya;
            dx  <= abs_dx;
            dy  <= neg_dy;
            err <= abs_dx + neg_dy;
            sx  <= (diff_x < 0) ? coord_t'(-1) : coord_t'(1);
            sy  <= (diff_y < 0) ? coord_t'(-1) : coord_t'(1);
        end else if (state == st_draw && oe && !at_end) begin
            if (step_x)
                x <= x + sx;
            if (step_y)
                y <= y + sy;
            err <= err_nx;
        end
    end

    a_done_not_drawing : assert property (@(posedge clk) disable iff (rst)
        !(done && drawing));

endmodule : draw_line

/* draw_triangle.sv */
////////////////////////////////////////////////////////////
// triangle outliner
// draws edges 0-1 then 1-2 then 2-0 through one line drawer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module draw_triangle (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,    // taken in idle only
    input  logic                  oe,       // low pauses the edge
    input  gfx_coord_pkg::coord_t x0,       // vertex 0
    input  gfx_coord_pkg::coord_t y0,
    input  gfx_coord_pkg::coord_t x1,       // vertex 1
    input  gfx_coord_pkg::coord_t y1,
    input  gfx_coord_pkg::coord_t x2,       // vertex 2
    input  gfx_coord_pkg::coord_t y2,
    output gfx_coord_pkg::coord_t x,        // current pixel
    output gfx_coord_pkg::coord_t y,
    output logic                  drawing,  // an edge is being drawn
    output logic                  done      // after third edge
);
    import gfx_coord_pkg::*;

    typedef enum logic [1:0] {st_idle, st_init, st_draw} state_t;

    state_t     state;
    logic [1:0] edge_id;                    // 0, 1 or 2
    logic       line_start;
    logic       line_done;
    coord_t     vx0, vy0, vx1, vy1, vx2, vy2; // latched vertices
    coord_t     lx0, ly0, lx1, ly1;           // endpoints of current edge

    // edge endpoints from the latched vertices
    always_comb begin
        case (edge_id)
            2'd0: begin
                lx0 = vx0;
                ly0 = vy0;
                lx1 = vx1;
                ly1 = vy1;
            end
            2'd1: begin
                lx0 = vx1;
                ly0 = vy1;
                lx1 = vx2;
                ly1 = vy2;
            end
            default: begin                  // closing edge
                lx0 = vx2;
                ly0 = vy2;
                lx1 = vx0;
                ly1 = vy0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            edge_id    <= 2'd0;
            line_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        edge_id <= 2'd0;
                        state   <= st_init;
                    end
                end
                st_init: begin              // one cycle per edge
                    line_start <= 1'b1;
                    state      <= st_draw;
                end
                st_draw: begin
                    if (line_done) begin
                        if (edge_id == 2'd2) begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end else begin
                            edge_id <= edge_id + 2'd1;
                            state   <= st_init;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            vx0 <= x0;
            vy0 <= y0;
            vx1 <= x1;
            vy1 <= y1;
            vx2 <= x2;
            vy2 <= y2;
        end
    end

    draw_line i_draw_line (
        .clk     (clk),
        .rst     (rst),
        .start   (line_start),
        .oe      (oe),
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (x),
        .y       (y),
        .drawing (drawing),
        .done    (line_done)
    );

    a_edge_range : assert property (@(posedge clk) disable iff (rst)
        edge_id <= 2'd2);

endmodule : draw_triangle

/* gfx_cmd_pkg.sv */
////////////////////////////////////////////////////////////
// shape command definitions
// opcode and colour types
////////////////////////////////////////////////////////////

package gfx_cmd_pkg;

    // shape selector on the command port
    typedef enum logic {
        op_line     = 1'b0,                           // x2/y2 unused
        op_triangle = 1'b1                            // outline only
    } shape_op_t;

    // pixel colour passed through to the framebuffer untouched
    localparam int colour_w = 8;

    typedef logic [colour_w-1:0] colour_t;

endpackage : gfx_cmd_pkg

/* gfx_coord_pkg.sv */
////////////////////////////////////////////////////////////
// coordinate and framebuffer geometry definitions
////////////////////////////////////////////////////////////

package gfx_coord_pkg;

    // signed screen coordinates
    localparam int coord_w = 16;                      // bits per coordinate

    typedef logic signed [coord_w-1:0] coord_t;       // x or y position

    // framebuffer rectangle in pixels
    localparam int fb_width  = 160;
    localparam int fb_height = 120;

    // linear pixel address is y * fb_width + x
    localparam int fb_addr_w = 15;                    // covers 160*120 pixels

    typedef logic [fb_addr_w-1:0] fb_addr_t;

endpackage : gfx_coord_pkg

/* gfx_draw_top.f */
gfx_coord_pkg.sv
gfx_cmd_pkg.sv
draw_line.sv
draw_triangle.sv
shape_engine.sv
pixel_clip_write.sv
gfx_draw_top.sv
tb_gfx_draw_top.sv

/* gfx_draw_top.sv */
////////////////////////////////////////////////////////////
// rasteriser top level
// shape engine into clip/write stage with done aligned
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gfx_draw_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_start,
    input  gfx_cmd_pkg::shape_op_t  cmd_op,
    input  gfx_coord_pkg::coord_t   x0,
    input  gfx_coord_pkg::coord_t   y0,
    input  gfx_coord_pkg::coord_t   x1,
    input  gfx_coord_pkg::coord_t   y1,
    input  gfx_coord_pkg::coord_t   x2,
    input  gfx_coord_pkg::coord_t   y2,
    input  gfx_cmd_pkg::colour_t    colour,
    input  logic                    oe,         // pause when low
    output logic                    fb_we,
    output gfx_coord_pkg::fb_addr_t fb_addr,
    output gfx_cmd_pkg::colour_t    fb_colour,
    output logic                    busy,
    output logic                    done        // after last write of shape
);
    import gfx_coord_pkg::*;
    import gfx_cmd_pkg::*;

    coord_t  px, py;
    logic    pix_valid;
    colour_t pix_colour;
    logic    shape_done;

    shape_engine i_shape_engine (
        .clk (clk), .rst (rst), .cmd_start (cmd_start), .cmd_op (cmd_op),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1), .x2 (x2), .y2 (y2),
        .colour (colour), .oe (oe), .px (px), .py (py),
        .pix_valid (pix_valid), .pix_colour (pix_colour),
        .busy (busy), .shape_done (shape_done)
    );

    pixel_clip_write i_pixel_clip_write (
        .clk (clk), .rst (rst), .px (px), .py (py),
        .pix_valid (pix_valid), .pix_colour (pix_colour),
        .fb_we (fb_we), .fb_addr (fb_addr), .fb_colour (fb_colour)
    );

    // match the one cycle of the write stage
    always_ff @(posedge clk) begin
        if (rst)
            done <= 1'b0;
        else
            done <= shape_done;
    end

endmodule : gfx_draw_top

/* pixel_clip_write.sv */
////////////////////////////////////////////////////////////
// framebuffer clip and write stage
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pixel_clip_write (
    input  logic                    clk,
    input  logic                    rst,
    input  gfx_coord_pkg::coord_t   px,         // signed pixel position
    input  gfx_coord_pkg::coord_t   py,
    input  logic                    pix_valid,
    input  gfx_cmd_pkg::colour_t    pix_colour,
    output logic                    fb_we,      // one cycle after pix_valid
    output gfx_coord_pkg::fb_addr_t fb_addr,    // y * fb_width + x
    output gfx_cmd_pkg::colour_t    fb_colour
);
    import gfx_coord_pkg::*;

    logic     on_screen;
    logic     keep;
    fb_addr_t addr_nx;

    // reject negative and past-the-edge coordinates
    assign on_screen = (px >= 0) && (py >= 0) &&
                       (px < fb_width) && (py < fb_height);
    assign keep      = pix_valid && on_screen;

    // max 119*160+159 so the cast never wraps on screen
    assign addr_nx   = fb_addr_t'(py * fb_width + px);

    always_ff @(posedge clk) begin
        if (rst)
            fb_we <= 1'b0;
        else
            fb_we <= keep;                      // no strobe for clipped pixels
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            fb_addr   <= addr_nx;
            fb_colour <= pix_colour;
        end
    end

    a_addr_in_fb : assert property (@(posedge clk) disable iff (rst)
        fb_we |-> (fb_addr < fb_width * fb_height));

endmodule : pixel_clip_write

/* shape_engine.sv */
////////////////////////////////////////////////////////////
// shape command engine
// starts the line or triangle drawer and merges pixels
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module shape_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cmd_start,  // one cycle pulse
    input  gfx_cmd_pkg::shape_op_t  cmd_op,
    input  gfx_coord_pkg::coord_t   x0,
    input  gfx_coord_pkg::coord_t   y0,
    input  gfx_coord_pkg::coord_t   x1,
    input  gfx_coord_pkg::coord_t   y1,
    input  gfx_coord_pkg::coord_t   x2,         // triangle only
    input  gfx_coord_pkg::coord_t   y2,
    input  gfx_cmd_pkg::colour_t    colour,
    input  logic                    oe,
    output gfx_coord_pkg::coord_t   px,         // active drawer pixel
    output gfx_coord_pkg::coord_t   py,
    output logic                    pix_valid,  // drawing and oe
    output gfx_cmd_pkg::colour_t    pix_colour,
    output logic                    busy,
    output logic                    shape_done
);
    import gfx_coord_pkg::*;
    import gfx_cmd_pkg::*;

    logic      accept;
    logic      line_start, tri_start;
    shape_op_t op_q;                            // opcode of shape in flight
    colour_t   colour_q;
    coord_t    line_x, line_y, tri_x, tri_y;
    logic      line_drawing, tri_drawing;
    logic      line_done, tri_done;
    logic      sel_drawing;

    assign accept     = cmd_start && !busy;     // pulses while busy are dropped
    assign line_start = accept && (cmd_op == op_line);
    assign tri_start  = accept && (cmd_op == op_triangle);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            op_q <= op_line;
        end else if (accept) begin
            busy <= 1'b1;
            op_q <= cmd_op;
        end else if (shape_done) begin
            busy <= 1'b0;                       // falls the cycle after done
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            colour_q <= colour;
    end

    // only the drawer that was started is ever active
    always_comb begin
        if (op_q == op_triangle) begin
            px          = tri_x;
            py          = tri_y;
            sel_drawing = tri_drawing;
            shape_done  = tri_done;
        end else begin
            px          = line_x;
            py          = line_y;
            sel_drawing = line_drawing;
            shape_done  = line_done;
        end
    end

    assign pix_valid  = sel_drawing && oe;
    assign pix_colour = colour_q;

    draw_line i_draw_line (
        .clk (clk), .rst (rst), .start (line_start), .oe (oe),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1),
        .x (line_x), .y (line_y), .drawing (line_drawing), .done (line_done)
    );

    draw_triangle i_draw_triangle (
        .clk (clk), .rst (rst), .start (tri_start), .oe (oe),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1), .x2 (x2), .y2 (y2),
        .x (tri_x), .y (tri_y), .drawing (tri_drawing), .done (tri_done)
    );

    a_one_drawer : assert property (@(posedge clk) disable iff (rst)
        !(line_drawing && tri_drawing));

endmodule : shape_engine

/* tb_gfx_draw_top.sv */
////////////////////////////////////////////////////////////
// testbench for the rasteriser top level
// directed and random shapes, framebuffer model, assertions
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_gfx_draw_top;
    import gfx_coord_pkg::*;
    import gfx_cmd_pkg::*;

    localparam int fb_size     = fb_width * fb_height;
    localparam int timeout_cyc = 6000;          // cycles per wait loop

    logic      clk = 1'b0;
    logic      rst, cmd_start, oe, fb_we, busy, done;
    shape_op_t cmd_op;
    coord_t    x0, y0, x1, y1, x2, y2;
    colour_t   colour, fb_colour;
    fb_addr_t  fb_addr;

    int      got_cnt [fb_size];                 // writes seen per address
    colour_t got_col [fb_size];
    int      exp_cnt [fb_size];                 // writes expected per address
    int      n_writes, n_done;
    int      mismatch_cnt = 0;
    int      fail_cnt     = 0;

    always #4 clk = ~clk;

    gfx_draw_top i_gfx_draw_top (
        .clk (clk), .rst (rst), .cmd_start (cmd_start), .cmd_op (cmd_op),
        .x0 (x0), .y0 (y0), .x1 (x1), .y1 (y1), .x2 (x2), .y2 (y2),
        .colour (colour), .oe (oe), .fb_we (fb_we), .fb_addr (fb_addr),
        .fb_colour (fb_colour), .busy (busy), .done (done)
    );

    // framebuffer model sampled at the falling edge
    always @(negedge clk) begin
        if (!rst && fb_we && fb_addr < fb_size) begin
            got_cnt[fb_addr]++;
            got_col[fb_addr] = fb_colour;
            n_writes++;
        end
        if (!rst && done)
            n_done++;
    end

    a_fb_range : assert property (@(posedge clk) disable iff (rst)
        fb_we |-> (fb_addr < fb_size))
        else begin
            fail_cnt++;
            $display("write strobe raised with address %0d outside the framebuffer", fb_addr);
        end

    a_pause : assert property (@(posedge clk) disable iff (rst) !oe |=> !fb_we)
        else begin
            fail_cnt++;
            $display("a write happened in the cycle after oe was low");
        end

    a_done_pulse : assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_cnt++;
            $display("done stayed high for more than one cycle");
        end

    a_reset : assert property (@(posedge clk) rst |=> (!busy && !done && !fb_we))
        else begin
            fail_cnt++;
            $display("busy, done or fb_we still high after a reset cycle");
        end

    function automatic void plot(input int px, input int py);
        if (px >= 0 && px < fb_width && py >= 0 && py < fb_height)
            exp_cnt[py * fb_width + px]++;      // clipped pixels never count
    endfunction

    // reference bresenham from endpoint a to endpoint b
    task automatic bres_line(input int xa, input int ya, input int xb, input int yb);
        int dx, dy, sx, sy, err, e2, xc, yc;
        dx  = (xb > xa) ? xb - xa : xa - xb;
        dy  = (yb > ya) ? ya - yb : yb - ya;    // kept negative
        sx  = (xa < xb) ? 1 : -1;
        sy  = (ya < yb) ? 1 : -1;
        err = dx + dy;
        xc  = xa;
        yc  = ya;
        forever begin
            plot(xc, yc);
            if (xc == xb && yc == yb)
                break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                xc  += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                yc  += sy;
            end
        end
    endtask

    task automatic check_frame(input string name, input colour_t col);
        for (int a = 0; a < fb_size; a++) begin
            assert (got_cnt[a] == exp_cnt[a])
                else begin
                    mismatch_cnt++;
                    $display("MISMATCH %s addr %0d writes: expected %0d, actual %0d",
                             name, a, exp_cnt[a], got_cnt[a]);
                end
            if (got_cnt[a] > 0)
                assert (got_col[a] == col)
                    else begin
                        mismatch_cnt++;
                        $display("MISMATCH %s addr %0d colour: expected %0h, actual %0h",
                                 name, a, col, got_col[a]);
                    end
        end
    endtask

    task automatic run_shape(input string name, input shape_op_t op, input int ax, input int ay,
                             input int bx, input int by, input int cx, input int cy,
                             input colour_t col, input bit rand_oe, input bit retrig);
        int cyc;
        for (int a = 0; a < fb_size; a++) begin
            got_cnt[a] = 0;
            exp_cnt[a] = 0;
        end
        n_writes = 0;
        n_done   = 0;
        bres_line(ax, ay, bx, by);
        if (op == op_triangle) begin
            bres_line(bx, by, cx, cy);
            bres_line(cx, cy, ax, ay);
        end
        cyc = 0;
        while (busy && cyc < timeout_cyc) begin
            @(negedge clk);
            cyc++;
        end
        if (busy) begin
            fail_cnt++;
            $display("%s: busy never went low before the command", name);
        end
        @(negedge clk);
        cmd_op    = op;
        x0        = ax;
        y0        = ay;
        x1        = bx;
        y1        = by;
        x2        = cx;
        y2        = cy;
        colour    = col;
        cmd_start = 1'b1;
        cyc       = 0;
        while ((cyc == 0 || !done) && cyc < timeout_cyc) begin
            @(negedge clk);
            cyc++;
            cmd_start = 1'b0;
            if (rand_oe)
                oe = ($urandom_range(0, 1) == 1);
            if (retrig && cyc == 3) begin   // second command while busy
                cmd_start = 1'b1;
                cmd_op    = op_line;
                x0        = 0;
                y0        = 0;
                x1        = 150;
                y1        = 110;
            end
        end
        if (!done) begin
            fail_cnt++;
            $display("%s: timed out waiting for done", name);
        end
        oe = 1'b1;
        repeat (4) @(negedge clk);          // room for a stray done
        assert (n_done == 1)
            else begin
                mismatch_cnt++;
                $display("MISMATCH %s done pulses: expected 1, actual %0d", name, n_done);
            end
        check_frame(name, col);
    endtask

    task automatic check_vertex(input string name, input int vx, input int vy);
        assert (got_cnt[vy * fb_width + vx] == 2)
            else begin
                mismatch_cnt++;
                $display("MISMATCH %s vertex (%0d,%0d): expected 2, actual %0d",
                         name, vx, vy, got_cnt[vy * fb_width + vx]);
            end
    endtask

    initial begin
        int        c [6];
        shape_op_t rop;
        colour_t   rcol;
        bit        roe;
        rst       = 1'b1;
        cmd_start = 1'b0;
        cmd_op    = op_line;
        x0        = 0;
        y0        = 0;
        x1        = 0;
        y1        = 0;
        x2        = 0;
        y2        = 0;
        colour    = '0;
        oe        = 1'b1;
        void'($urandom(91712));
        repeat (5) @(negedge clk);
        rst = 1'b0;

        run_shape("hline", op_line, 10, 20, 49, 20, 0, 0, 8'h3c, 0, 0);
        assert (n_writes == 40)
            else begin
                mismatch_cnt++;
                $display("MISMATCH hline write count: expected 40, actual %0d", n_writes);
            end
        run_shape("vline", op_line, 5, 3, 5, 90, 0, 0, 8'h51, 0, 0);
        run_shape("steep_diag", op_line, 30, 10, 45, 100, 0, 0, 8'ha7, 0, 0);
        run_shape("triangle", op_triangle, 20, 20, 100, 30, 50, 90, 8'h7e, 0, 0);
        check_vertex("triangle", 20, 20);
        check_vertex("triangle", 100, 30);
        check_vertex("triangle", 50, 90);
        run_shape("clip_line", op_line, -20, 50, 180, 60, 0, 0, 8'h19, 0, 0);
        run_shape("pause_line", op_line, 30, 10, 45, 100, 0, 0, 8'ha7, 1, 0);
        run_shape("pause_tri", op_triangle, 20, 20, 100, 30, 50, 90, 8'h7e, 1, 0);
        run_shape("busy_retrig", op_triangle, 60, 5, 140, 70, 10, 100, 8'hc2, 0, 1);

        for (int i = 0; i < 12; i++) begin
            for (int k = 0; k < 6; k++)
                c[k] = int'($urandom_range(0, 240)) - 40;   // -40 to 200
            rop  = ($urandom_range(0, 1) == 1) ? op_triangle : op_line;
            rcol = colour_t'($urandom_range(0, 255));
            roe  = ($urandom_range(0, 1) == 1);
            run_shape($sformatf("random_%0d", i), rop, c[0], c[1], c[2], c[3],
                      c[4], c[5], rcol, roe, 0);
        end

        // reset in the middle of a triangle
        @(negedge clk);
        cmd_op    = op_triangle;
        x0        = 10;
        y0        = 10;
        x1        = 150;
        y1        = 20;
        cmd_start = 1'b1;
        @(negedge clk);
        cmd_start = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!busy && !done && !fb_we)
            else begin
                fail_cnt++;
                $display("busy, done or fb_we high after reset was released");
            end

        $display("closing: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_gfx_draw_top
